/* hw/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ********************
// core data path
// ********************
// register and immediate width
`define CPU_DATA_W 16
// register file size, register address is 2 bits
`define CPU_N_REGS 4
// opcode 4 + condition 2 + register 2 + immediate 16
`define CPU_INSTR_W 24

// program memory, 32 words
`define CPU_PROG_DEPTH 32
`define CPU_PADDR_W 5

// ********************
// apb address map
// ********************
`define APB_ADDR_W 8
`define APB_CTRL_ADDR 8'h00
`define APB_STATUS_ADDR 8'h04
// program word n sits at base + 4*n
`define APB_PROG_BASE 8'h80

// output stream buffer entries
`define OUT_BUF_DEPTH 4

`endif

/* hw/cpu_isa_pkg.sv */
`include "cpu_settings.svh"

package cpu_isa_pkg;

	// instruction opcodes, codes not listed here are undefined
	typedef enum logic [3:0] {
		NOP     = 4'h0,
		MV_R_C  = 4'h1,
		ADD_R_C = 4'h2,
		// carry means borrow
		SUB_R_C = 4'h3,
		AND_R_C = 4'h4,
		SHR1    = 4'h5,
		JMP     = 4'h6,
		OUT     = 4'h7,
		HALT    = 4'h8
	} opcode_e;

	// condition checked against the flags before execution
	typedef enum logic [1:0] {
		ALWAYS   = 2'd0,
		IF_ZERO  = 2'd1,
		IF_NZ    = 2'd2,
		IF_CARRY = 2'd3
	} cond_e;

	// instruction word, msb first
	typedef struct packed {
		opcode_e opcode;
		cond_e cond;
		logic [$clog2(`CPU_N_REGS)-1:0] reg_addr;
		logic [`CPU_DATA_W-1:0] imm;
	} instr_t;

endpackage

/* hw/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

	// core run state, kept by fetch
	typedef enum logic {
		IDLE = 1'b0,
		RUN  = 1'b1
	} run_state_e;

	// condition flags
	typedef struct packed {
		logic zero;
		logic carry;
	} flags_t;

endpackage

/* hw/instr_bus_if.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

// fetch to execute, with control coming back
interface instr_bus_if;

	// instruction word and its valid bit
	cpu_isa_pkg::instr_t instr;
	logic instr_valid;
	// start pulse, exec clears registers and flags
	logic start;
	// OUT waiting on a full buffer
	logic stall;
	// taken jump, fetch drops what it holds
	logic jump;
	logic [`CPU_PADDR_W-1:0] jump_addr;
	// halt pulse, bad_op marks an undefined opcode
	logic halt;
	logic bad_op;

	modport fetch (
		output instr, instr_valid, start,
		input stall, jump, jump_addr, halt, bad_op
	);

	modport exec (
		input instr, instr_valid, start,
		output stall, jump, jump_addr, halt, bad_op
	);

endinterface

/* hw/prog_load_if.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

// apb side to fetch: program writes, start and status
interface prog_load_if;

	// program memory write port
	logic prog_we;
	logic [`CPU_PADDR_W-1:0] prog_addr;
	logic [`CPU_INSTR_W-1:0] prog_wdata;
	// one cycle, from a CTRL write
	logic start;
	// run state and sticky end status
	logic running;
	logic halted;
	logic bad_op;

	modport loader (
		output prog_we, prog_addr, prog_wdata, start,
		input running, halted, bad_op
	);

	modport fetch (
		input prog_we, prog_addr, prog_wdata, start,
		output running, halted, bad_op
	);

endinterface

/* hw/apb_prog_loader.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module apb_prog_loader (
	input  logic CLK,
	input  logic reset,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	prog_load_if.loader pl
);

	logic [`APB_ADDR_W-1:0] prog_off;
	logic ctrl_hit;
	logic status_hit;
	logic prog_hit;
	logic setup;
	logic access;
	logic bad_access;

	// ********************
	// address decode
	// ********************
	assign prog_off = paddr - `APB_PROG_BASE;
	assign ctrl_hit = (paddr == `APB_CTRL_ADDR);
	assign status_hit = (paddr == `APB_STATUS_ADDR);
	// word aligned and inside the program memory
	assign prog_hit = (paddr >= `APB_PROG_BASE) && (prog_off[1:0] == 2'b00)
		&& (prog_off[`APB_ADDR_W-1:2] < `CPU_PROG_DEPTH);

	// apb phases
	assign setup = psel & ~penable;
	assign access = psel & penable;

	// unmapped, or a program write or start while the core runs
	assign bad_access = ~(ctrl_hit | status_hit | prog_hit)
		| (pwrite & pl.running & (prog_hit | (ctrl_hit & pwdata[0])));

	// ********************
	// response registers
	// ********************
	// decided in the setup phase, shown in the access phase
	always_ff @(posedge CLK) begin
		if (reset) begin
			pslverr <= 1'b0;
			prdata <= '0;
		end else begin
			pslverr <= setup & bad_access;
			if (setup) begin
				// bit 0 running, bit 1 halted, bit 2 bad opcode
				prdata <= (status_hit & ~pwrite)
					? {29'b0, pl.bad_op, pl.halted, pl.running} : '0;
			end
		end
	end

	// no wait states
	assign pready = 1'b1;

	// program word write goes straight to the memory port
	assign pl.prog_we = access & pwrite & prog_hit & ~pslverr;
	assign pl.prog_addr = prog_off[`CPU_PADDR_W+1:2];
	assign pl.prog_wdata = pwdata[`CPU_INSTR_W-1:0];

	// ctrl bit 0 starts from address 0
	assign pl.start = access & pwrite & ctrl_hit & pwdata[0] & ~pslverr;

endmodule

/* hw/instr_fetch.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module instr_fetch (
	input logic CLK,
	input logic reset,
	prog_load_if.fetch pl,
	instr_bus_if.fetch bus
);

	logic [`CPU_INSTR_W-1:0] prog_mem [`CPU_PROG_DEPTH];
	cpu_ctrl_pkg::run_state_e state;
	logic [`CPU_PADDR_W-1:0] pc;
	logic advance;

	// program memory write port, loader only writes while idle
	always_ff @(posedge CLK) begin
		if (pl.prog_we)
			prog_mem[pl.prog_addr] <= pl.prog_wdata;
	end

	// move on unless stalled, jumping or halting
	assign advance = (state == cpu_ctrl_pkg::RUN) & ~bus.stall & ~bus.jump & ~bus.halt;

	// synchronous read, word at pc is valid the next cycle
	always_ff @(posedge CLK) begin
		if (advance)
			bus.instr <= cpu_isa_pkg::instr_t'(prog_mem[pc]);
	end

	// ********************
	// pc and run state
	// ********************
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= cpu_ctrl_pkg::IDLE;
			pc <= '0;
			bus.instr_valid <= 1'b0;
			pl.halted <= 1'b0;
			pl.bad_op <= 1'b0;
		end else if (pl.start) begin
			// fresh run from address 0, end status cleared
			state <= cpu_ctrl_pkg::RUN;
			pc <= '0;
			bus.instr_valid <= 1'b0;
			pl.halted <= 1'b0;
			pl.bad_op <= 1'b0;
		end else if (state == cpu_ctrl_pkg::RUN) begin
			if (bus.halt) begin
				state <= cpu_ctrl_pkg::IDLE;
				bus.instr_valid <= 1'b0;
				pl.halted <= 1'b1;
				pl.bad_op <= bus.bad_op;
			end else if (bus.jump) begin
				// drop the fetched word, one bubble
				pc <= bus.jump_addr;
				bus.instr_valid <= 1'b0;
			end else if (!bus.stall) begin
				// wraps to 0 after the last word
				pc <= (pc == `CPU_PROG_DEPTH - 1) ? '0 : pc + 1'b1;
				bus.instr_valid <= 1'b1;
			end
			// on stall everything holds
		end
	end

	assign pl.running = (state == cpu_ctrl_pkg::RUN);
	assign bus.start = pl.start;

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module exec_unit (
	input  logic CLK,
	input  logic reset,
	instr_bus_if.exec bus,
	output logic push,
	output logic [`CPU_DATA_W-1:0] push_data,
	input  logic full
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_N_REGS];
	cpu_ctrl_pkg::flags_t flags;
	logic [`CPU_DATA_W-1:0] src;
	logic [`CPU_DATA_W-1:0] alu_res;
	logic alu_c;
	logic wr_reg;
	logic sets_z;
	logic sets_c;
	logic is_jmp;
	logic is_out;
	logic is_halt;
	logic undefined;
	logic cond_true;
	logic active;
	logic stall;
	logic exec_ok;

	// source register, also the OUT value
	assign src = regs[bus.instr.reg_addr];

	// ********************
	// condition check
	// ********************
	always_comb begin
		case (bus.instr.cond)
			cpu_isa_pkg::ALWAYS:   cond_true = 1'b1;
			cpu_isa_pkg::IF_ZERO:  cond_true = flags.zero;
			cpu_isa_pkg::IF_NZ:    cond_true = ~flags.zero;
			cpu_isa_pkg::IF_CARRY: cond_true = flags.carry;
			default:               cond_true = 1'b0;
		endcase
	end

	// ********************
	// integer operations
	// ********************
	always_comb begin
		alu_res = src;
		alu_c = flags.carry;
		wr_reg = 1'b0;
		sets_z = 1'b0;
		sets_c = 1'b0;
		is_jmp = 1'b0;
		is_out = 1'b0;
		is_halt = 1'b0;
		undefined = 1'b0;
		case (bus.instr.opcode)
			cpu_isa_pkg::NOP: begin
			end
			cpu_isa_pkg::MV_R_C: begin
				alu_res = bus.instr.imm;
				wr_reg = 1'b1;
			end
			cpu_isa_pkg::ADD_R_C: begin
				{alu_c, alu_res} = {1'b0, src} + {1'b0, bus.instr.imm};
				wr_reg = 1'b1;
				sets_z = 1'b1;
				sets_c = 1'b1;
			end
			cpu_isa_pkg::SUB_R_C: begin
				// top bit of the 17-bit difference is the borrow
				{alu_c, alu_res} = {1'b0, src} - {1'b0, bus.instr.imm};
				wr_reg = 1'b1;
				sets_z = 1'b1;
				sets_c = 1'b1;
			end
			cpu_isa_pkg::AND_R_C: begin
				alu_res = src & bus.instr.imm;
				wr_reg = 1'b1;
				sets_z = 1'b1;
			end
			cpu_isa_pkg::SHR1: begin
				// bit 0 drops into carry
				{alu_res, alu_c} = {1'b0, src};
				wr_reg = 1'b1;
				sets_z = 1'b1;
				sets_c = 1'b1;
			end
			cpu_isa_pkg::JMP:  is_jmp = 1'b1;
			cpu_isa_pkg::OUT:  is_out = 1'b1;
			cpu_isa_pkg::HALT: is_halt = 1'b1;
			default:           undefined = 1'b1;
		endcase
	end

	// false condition makes it a nop
	assign active = bus.instr_valid & cond_true;
	// OUT holds in place while the buffer is full
	assign stall = active & is_out & full;
	assign exec_ok = active & ~stall;

	assign bus.stall = stall;
	assign bus.jump = exec_ok & is_jmp;
	assign bus.jump_addr = bus.instr.imm[`CPU_PADDR_W-1:0];
	assign bus.halt = exec_ok & (is_halt | undefined);
	assign bus.bad_op = exec_ok & undefined;

	assign push = exec_ok & is_out;
	assign push_data = src;

	// flags, only those the opcode defines
	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (bus.start) begin
			flags <= '0;
		end else if (exec_ok) begin
			if (sets_z)
				flags.zero <= (alu_res == '0);
			if (sets_c)
				flags.carry <= alu_c;
		end
	end

	// register file, cleared on start
	always_ff @(posedge CLK) begin
		if (bus.start) begin
			for (int i = 0; i < `CPU_N_REGS; i++)
				regs[i] <= '0;
		end else if (exec_ok & wr_reg) begin
			regs[bus.instr.reg_addr] <= alu_res;
		end
	end

endmodule

/* hw/out_stream_buf.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module out_stream_buf (
	input  logic CLK,
	input  logic reset,
	input  logic push,
	input  logic [`CPU_DATA_W-1:0] push_data,
	output logic full,
	input  logic out_ready,
	output logic [`CPU_DATA_W-1:0] out_data,
	output logic out_valid
);

	localparam int PTR_W = $clog2(`OUT_BUF_DEPTH);

	logic [`CPU_DATA_W-1:0] fifo_mem [`OUT_BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic wr_en;
	logic rd_en;

	assign full = (count == `OUT_BUF_DEPTH);
	// oldest word at the head
	assign out_valid = (count != '0);
	assign out_data = fifo_mem[rd_ptr];

	assign wr_en = push & ~full;
	assign rd_en = out_valid & out_ready;

	// storage
	always_ff @(posedge CLK) begin
		if (wr_en)
			fifo_mem[wr_ptr] <= push_data;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave the count alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_top (
	input  logic CLK,
	input  logic reset,
	// apb slave
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// output stream
	input  logic out_ready,
	output logic [`CPU_DATA_W-1:0] out_data,
	output logic out_valid
);

	// core to output buffer
	logic push;
	logic [`CPU_DATA_W-1:0] push_data;
	logic full;

	prog_load_if pl_if ();
	instr_bus_if ib_if ();

	// ********************
	// host side
	// ********************
	apb_prog_loader loader_i (
		.CLK(CLK),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.pl(pl_if.loader)
	);

	// ********************
	// core
	// ********************
	instr_fetch fetch_i (
		.CLK(CLK),
		.reset(reset),
		.pl(pl_if.fetch),
		.bus(ib_if.fetch)
	);

	exec_unit exec_i (
		.CLK(CLK),
		.reset(reset),
		.bus(ib_if.exec),
		.push(push),
		.push_data(push_data),
		.full(full)
	);

	// output side
	out_stream_buf obuf_i (
		.CLK(CLK),
		.reset(reset),
		.push(push),
		.push_data(push_data),
		.full(full),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_valid(out_valid)
	);

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic CLK,
	output logic reset
);

	// 4 ns period
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// reset held for 16 rising edges, released just after an edge
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge CLK);
		#1;
		reset = 1'b0;
	end

endmodule

/* verif/tb_cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module tb_cpu_top;

	// 20 programs at 2000 cycles each
	localparam int CYCLE_LIMIT = 20 * 2000;
	// out_ready modes
	localparam int HOLD_LOW = 0;
	localparam int HOLD_HIGH = 1;
	localparam int RANDOM_READY = 2;

	logic CLK;
	logic reset;
	logic [`APB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic out_ready;
	logic [`CPU_DATA_W-1:0] out_data;
	logic out_valid;

	integer seed;
	int ready_mode;
	int cycles;
	int errors;
	int tests_run;
	int tests_failed;
	int test_err_base;

	// program image that the model also reads
	logic [`CPU_INSTR_W-1:0] prog [`CPU_PROG_DEPTH];
	logic [`CPU_DATA_W-1:0] exp_q [$];
	logic [`CPU_DATA_W-1:0] rx_q [$];
	logic exp_bad;

	tb_clock_gen clk_gen_i (
		.CLK(CLK),
		.reset(reset)
	);

	cpu_top cpu_top_i (
		.CLK(CLK),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_valid(out_valid)
	);

	// ********************
	// random helpers
	// ********************
	// uniform 0 .. n-1
	function automatic int pick(input int n);
		int rv;
		rv = $random(seed) & 32'h7fff_ffff;
		return rv % n;
	endfunction

	// immediate with small values now and then so zero flags show up
	function automatic logic [15:0] rand_imm();
		logic [15:0] v;
		v = 16'(pick(65536));
		if (pick(4) == 0)
			v = 16'(pick(4));
		return v;
	endfunction

	function automatic logic [`CPU_INSTR_W-1:0] make_instr(input logic [3:0] op,
		input logic [1:0] cond, input logic [1:0] r, input logic [15:0] imm);
		return {op, cond, r, imm};
	endfunction

	// fills words first .. n-2 at random and puts HALT in word n-1
	// jumps only go forward and stay inside the program
	task automatic gen_program(input bit with_jumps, input int first, input int n);
		logic [3:0] op;
		logic [1:0] cond;
		logic [15:0] imm;
		int sel;
		int i;
		for (i = first; i < n - 1; i++) begin
			sel = pick(with_jumps ? 8 : 7);
			case (sel)
				0: op = cpu_isa_pkg::MV_R_C;
				1: op = cpu_isa_pkg::ADD_R_C;
				2: op = cpu_isa_pkg::SUB_R_C;
				3: op = cpu_isa_pkg::AND_R_C;
				4: op = cpu_isa_pkg::SHR1;
				7: op = cpu_isa_pkg::JMP;
				default: op = cpu_isa_pkg::OUT;
			endcase
			if (with_jumps)
				cond = 2'(pick(4));
			else
				cond = cpu_isa_pkg::ALWAYS;
			imm = rand_imm();
			if (sel == 7)
				imm[4:0] = 5'(i + 1 + pick(n - 1 - i));
			prog[i] = make_instr(op, cond, 2'(pick(4)), imm);
		end
		prog[n-1] = make_instr(cpu_isa_pkg::HALT, cpu_isa_pkg::ALWAYS, 2'd0, rand_imm());
	endtask

	// ********************
	// isa model
	// ********************
	task automatic run_model(input int n);
		logic [`CPU_DATA_W-1:0] mreg [`CPU_N_REGS];
		logic [16:0] wide;
		logic [3:0] op;
		logic [1:0] cond;
		logic [1:0] r;
		logic [15:0] imm;
		logic zf;
		logic cf;
		logic take;
		logic done;
		int pc;
		int steps;
		exp_q.delete();
		exp_bad = 1'b0;
		// start clears registers and flags
		for (pc = 0; pc < `CPU_N_REGS; pc++)
			mreg[pc] = '0;
		zf = 1'b0;
		cf = 1'b0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done) begin
			if (pc >= n || steps > 1000) begin
				$display("model error: program ran past its end at word %0d", pc);
				errors++;
				done = 1'b1;
			end else begin
				{op, cond, r, imm} = prog[pc];
				steps++;
				pc++;
				case (cond)
					cpu_isa_pkg::ALWAYS:  take = 1'b1;
					cpu_isa_pkg::IF_ZERO: take = zf;
					cpu_isa_pkg::IF_NZ:   take = !zf;
					default:              take = cf;
				endcase
				// nothing happens on a false condition
				if (take) begin
					case (op)
						cpu_isa_pkg::NOP: begin
						end
						cpu_isa_pkg::MV_R_C: mreg[r] = imm;
						cpu_isa_pkg::ADD_R_C: begin
							wide = {1'b0, mreg[r]} + {1'b0, imm};
							mreg[r] = wide[15:0];
							cf = wide[16];
							zf = (wide[15:0] == '0);
						end
						cpu_isa_pkg::SUB_R_C: begin
							// borrow when imm is larger
							wide = {1'b0, mreg[r]} - {1'b0, imm};
							mreg[r] = wide[15:0];
							cf = wide[16];
							zf = (wide[15:0] == '0);
						end
						cpu_isa_pkg::AND_R_C: begin
							mreg[r] = mreg[r] & imm;
							zf = (mreg[r] == '0);
						end
						cpu_isa_pkg::SHR1: begin
							cf = mreg[r][0];
							mreg[r] = mreg[r] >> 1;
							zf = (mreg[r] == '0);
						end
						cpu_isa_pkg::JMP: pc = int'(imm[4:0]);
						cpu_isa_pkg::OUT: exp_q.push_back(mreg[r]);
						cpu_isa_pkg::HALT: done = 1'b1;
						default: begin
							exp_bad = 1'b1;
							done = 1'b1;
						end
					endcase
				end
			end
		end
	endtask

	// ********************
	// apb master
	// ********************
	// pready must be high in every access phase
	task automatic verify_pready();
		if (pready !== 1'b1) begin
			$display("MISMATCH at %0t: pready low in the access phase", $time);
			errors++;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		output logic err);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge CLK);
		#1;
		penable = 1'b1;
		// response is already up in the access phase
		err = pslverr;
		verify_pready();
		@(posedge CLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge CLK);
		#1;
		penable = 1'b1;
		data = prdata;
		err = pslverr;
		verify_pready();
		@(posedge CLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// ********************
	// run control
	// ********************
	task automatic load_program(input int n);
		logic err;
		int i;
		for (i = 0; i < n; i++) begin
			apb_write(`APB_PROG_BASE + 8'(4 * i), {8'b0, prog[i]}, err);
			if (err) begin
				$display("program write to word %0d was refused while the core was idle", i);
				errors++;
			end
		end
	endtask

	task automatic start_core();
		logic err;
		rx_q.delete();
		apb_write(`APB_CTRL_ADDR, 32'h1, err);
		if (err) begin
			$display("start was refused while the core was idle");
			errors++;
		end
	endtask

	// poll STATUS until halted
	task automatic wait_halted();
		logic [31:0] st;
		logic err;
		st = '0;
		while (st[1] !== 1'b1)
			apb_read(`APB_STATUS_ADDR, st, err);
	endtask

	// let the buffer empty out after the halt
	task automatic drain_output();
		while (out_valid !== 1'b0) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic check_outputs(input string what);
		logic [31:0] st;
		logic err;
		int i;
		if (rx_q.size() != exp_q.size()) begin
			$display("MISMATCH at %0t: %0s sent %0d words, expected %0d",
				$time, what, rx_q.size(), exp_q.size());
			errors++;
		end
		for (i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
			if (rx_q[i] !== exp_q[i]) begin
				$display("MISMATCH at %0t: %0s word %0d is %h, expected %h",
					$time, what, i, rx_q[i], exp_q[i]);
				errors++;
			end
		end
		apb_read(`APB_STATUS_ADDR, st, err);
		if (st !== {29'b0, exp_bad, 2'b10}) begin
			$display("MISMATCH at %0t: %0s ends with status %h, expected %h",
				$time, what, st, {29'b0, exp_bad, 2'b10});
			errors++;
		end
	endtask

	task automatic run_program(input string what, input int n, input int mode);
		load_program(n);
		run_model(n);
		ready_mode = mode;
		start_core();
		wait_halted();
		ready_mode = HOLD_HIGH;
		drain_output();
		check_outputs(what);
	endtask

	task automatic end_test(input string what);
		tests_run++;
		if (errors != test_err_base) begin
			tests_failed++;
			$display("test %0s: failed with %0d errors", what, errors - test_err_base);
		end else begin
			$display("test %0s: passed", what);
		end
		test_err_base = errors;
	endtask

	// out_ready follows the mode set by the test sequence
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge CLK);
			#1;
			if (ready_mode == RANDOM_READY)
				out_ready = (pick(2) == 1);
			else
				out_ready = (ready_mode == HOLD_HIGH);
		end
	end

	// collects every accepted word
	always @(posedge CLK) begin
		if (!reset && out_valid === 1'b1 && out_ready === 1'b1)
			rx_q.push_back(out_data);
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles without finishing", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ********************
	// test sequence
	// ********************
	initial begin
		logic [31:0] rd;
		logic err;
		logic [15:0] a;
		int i;
		int n;
		seed = 32'h01a5_427e;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err_base = 0;
		ready_mode = HOLD_HIGH;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		wait (reset == 1'b0);
		@(posedge CLK);
		#1;

		// quiet after reset with nothing started
		apb_read(`APB_STATUS_ADDR, rd, err);
		if (rd !== 32'h0 || err !== 1'b0) begin
			$display("MISMATCH at %0t: status after reset %h err %b", $time, rd, err);
			errors++;
		end
		for (i = 0; i < 8; i++) begin
			if (out_valid !== 1'b0 || pslverr !== 1'b0) begin
				$display("MISMATCH at %0t: out_valid or pslverr high after reset", $time);
				errors++;
			end
			@(posedge CLK);
			#1;
		end
		end_test("after reset");

		for (i = 0; i < 4; i++) begin
			n = 8 + pick(16);
			gen_program(1'b0, 0, n);
			run_program("arithmetic", n, HOLD_HIGH);
		end
		end_test("arithmetic");

		for (i = 0; i < 4; i++) begin
			n = 10 + pick(20);
			gen_program(1'b1, 0, n);
			run_program("conditions", n, HOLD_HIGH);
		end
		end_test("conditions and jumps");

		// out_ready toggles at random
		for (i = 0; i < 4; i++) begin
			n = 10 + pick(20);
			gen_program(1'b1, 0, n);
			run_program("back-pressure", n, RANDOM_READY);
		end
		end_test("back-pressure");

		// undefined opcode (code 9 to 15) in word n
		n = 3 + pick(8);
		gen_program(1'b0, 0, n + 4);
		prog[n] = make_instr(4'h9 + 4'(pick(7)), cpu_isa_pkg::ALWAYS, 2'(pick(4)), rand_imm());
		run_program("bad opcode", n + 4, RANDOM_READY);

		// six OUTs that get stuck on the fifth while out_ready is low
		a = rand_imm();
		prog[0] = make_instr(cpu_isa_pkg::MV_R_C, cpu_isa_pkg::ALWAYS, 2'd0, a);
		for (i = 1; i < 7; i++)
			prog[i] = make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::ALWAYS, 2'd0, 16'h0);
		prog[7] = make_instr(cpu_isa_pkg::MV_R_C, cpu_isa_pkg::ALWAYS, 2'd1, ~a);
		prog[8] = make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::ALWAYS, 2'd1, 16'h0);
		// 1 shifted right leaves zero and carry set for the restart
		prog[9] = make_instr(cpu_isa_pkg::MV_R_C, cpu_isa_pkg::ALWAYS, 2'd2, 16'h0001);
		prog[10] = make_instr(cpu_isa_pkg::SHR1, cpu_isa_pkg::ALWAYS, 2'd2, 16'h0);
		prog[11] = make_instr(cpu_isa_pkg::HALT, cpu_isa_pkg::ALWAYS, 2'd0, 16'h0);
		ready_mode = HOLD_LOW;
		load_program(12);
		run_model(12);
		start_core();
		// word 8 would send r0 instead of r1 if the write got through
		apb_write(`APB_PROG_BASE + 8'd32,
			{8'b0, make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::ALWAYS, 2'd0, 16'h0)}, err);
		if (err !== 1'b1) begin
			$display("program write while running was not refused");
			errors++;
		end
		apb_write(`APB_CTRL_ADDR, 32'h1, err);
		if (err !== 1'b1) begin
			$display("start while running was not refused");
			errors++;
		end
		apb_write(8'h40, 32'h1, err);
		if (err !== 1'b1) begin
			$display("write to an unmapped address was not refused");
			errors++;
		end
		apb_read(8'h08, rd, err);
		if (err !== 1'b1 || rd !== 32'h0) begin
			$display("MISMATCH at %0t: unmapped read gave %h err %b", $time, rd, err);
			errors++;
		end
		// bad_op from the last program is gone
		apb_read(`APB_STATUS_ADDR, rd, err);
		if (rd !== 32'h1) begin
			$display("MISMATCH at %0t: status while stalled %h, expected 1", $time, rd);
			errors++;
		end
		ready_mode = RANDOM_READY;
		wait_halted();
		ready_mode = HOLD_HIGH;
		drain_output();
		check_outputs("write while running");
		end_test("errors");

		// old registers must not leak into the new run
		for (i = 0; i < 4; i++)
			prog[i] = make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::ALWAYS, 2'(i), 16'h0);
		prog[4] = make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::ALWAYS, 2'd1, 16'h0);
		// flags left set by the last run would let these two through
		prog[5] = make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::IF_ZERO, 2'd2, 16'h0);
		prog[6] = make_instr(cpu_isa_pkg::OUT, cpu_isa_pkg::IF_CARRY, 2'd3, 16'h0);
		prog[7] = make_instr(cpu_isa_pkg::MV_R_C, cpu_isa_pkg::IF_NZ, 2'd0, rand_imm());
		n = 14 + pick(12);
		gen_program(1'b1, 8, n);
		ready_mode = HOLD_LOW;
		load_program(n);
		run_model(n);
		start_core();
		apb_read(`APB_STATUS_ADDR, rd, err);
		if (rd !== 32'h1) begin
			$display("MISMATCH at %0t: status after restart %h, expected 1", $time, rd);
			errors++;
		end
		ready_mode = RANDOM_READY;
		wait_halted();
		ready_mode = HOLD_HIGH;
		drain_output();
		check_outputs("restart");
		end_test("restart");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* cpu_top.f */
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/instr_bus_if.sv
hw/prog_load_if.sv
hw/apb_prog_loader.sv
hw/instr_fetch.sv
hw/exec_unit.sv
hw/out_stream_buf.sv
hw/cpu_top.sv
verif/tb_clock_gen.sv
verif/tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_cpu_top -f cpu_top.f -o tb_cpu_top
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0
